//--- common/ooo_defines.svh
// widths and depths for the out-of-order core
// PREG_W and ROB_W are not derived, keep them in step with
// PREG_NUM and ROB_DEPTH when resizing
// ROB_DEPTH must stay a power of two, its pointers wrap freely
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

`define XLEN       32
`define AREG_W     5
`define PREG_NUM   48      // 32 architectural + 16 rename
`define PREG_W     6
`define ROB_DEPTH  8
`define ROB_W      3
`define RS_DEPTH   4
`define ZERO_REG   0

// only these two opcode groups are decoded
`define RV32_OP      7'b0110011
`define RV32_OP_IMM  7'b0010011

`endif

//--- common/ooo_pkg.sv
// shared types of the core
// inst_t is one raw word seen either as R-type or as I-type,
// the opcode decides which view is meaningful
`default_nettype none
`include "ooo_defines.svh"

package ooo_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;    // OP
        i_view_t i_view;    // OP-IMM
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
    } alu_func_e;

    // one source operand as held in the station
    typedef struct packed {
        logic [`XLEN-1:0]   value;
        logic               ready;
        logic [`PREG_W-1:0] tag;    // producer preg while not ready
    } rs_operand_t;

    typedef struct packed {
        rs_operand_t        opa;
        rs_operand_t        opb;
        alu_func_e          func;
        logic [`PREG_W-1:0] dest_preg;
        logic [`ROB_W-1:0]  rob_idx;
    } rs_entry_t;

endpackage

`default_nettype wire

//--- common/cdb_if.sv
// common data bus, one producer (the ALU) and many listeners
// valid is high for exactly one cycle per result
`timescale 1ns/10ps
`default_nettype none
`include "ooo_defines.svh"

interface cdb_if;
    logic               valid;
    logic [`PREG_W-1:0] preg;      // destination tag
    logic [`ROB_W-1:0]  rob_idx;
    logic [`XLEN-1:0]   value;

    modport src (output valid, output preg, output rob_idx, output value);
    modport dst (input valid, input preg, input rob_idx, input value);
endinterface

`default_nettype wire

//--- rename/rat.sv
// rename table, architectural to physical register
// lookups are combinational, the update lands at the dispatch edge
// no checkpoints, there is no recovery path
`timescale 1ns/10ps
`default_nettype none
`include "ooo_defines.svh"

module rat (
    input  logic                clock,
    input  logic                reset,
    input  logic                fire,
    input  logic [`AREG_W-1:0]  opa_areg,
    input  logic [`AREG_W-1:0]  opb_areg,
    input  logic [`AREG_W-1:0]  dest_areg,
    input  logic [`PREG_W-1:0]  new_preg,
    output logic [`PREG_W-1:0]  opa_preg,
    output logic [`PREG_W-1:0]  opb_preg,
    output logic [`PREG_W-1:0]  old_preg
);
    localparam int AREG_NUM = 1 << `AREG_W;

    logic [`PREG_W-1:0] map [AREG_NUM];

    assign opa_preg = map[opa_areg];
    assign opb_preg = map[opb_areg];
    assign old_preg = map[dest_areg];   // becomes prev_preg in the ROB

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < AREG_NUM; i++)
                map[i] <= `PREG_W'(i);  // identity
        end else if (fire && dest_areg != `ZERO_REG) begin
            map[dest_areg] <= new_preg;
        end
    end

    // preg 0 is x0 for good, a real rename never lands on it
    assert property (@(posedge clock) disable iff (reset)
        fire && dest_areg != `ZERO_REG |-> new_preg != '0)
        else $error("rename of x%0d onto preg 0", dest_areg);

endmodule

`default_nettype wire

//--- rename/prf.sv
// physical register file with ready bits and the free list
// preg 0 stays x0, CDB writes to it are dropped
// pregs 0..31 start ready and zero, the rest start free
// a same-cycle CDB result is forwarded to the dispatch reads
`timescale 1ns/10ps
`default_nettype none
`include "ooo_defines.svh"

module prf (
    input  logic                clock,
    input  logic                reset,
    input  logic                fire,
    input  logic                alloc,          // dest is not x0
    input  logic [`PREG_W-1:0]  opa_preg,
    input  logic [`PREG_W-1:0]  opb_preg,
    output logic                opa_ready,
    output logic [`XLEN-1:0]    opa_value,
    output logic                opb_ready,
    output logic [`XLEN-1:0]    opb_value,
    output logic [`PREG_W-1:0]  new_preg,
    output logic                free_empty,
    cdb_if.dst                  cdb,
    input  logic                commit_valid,
    input  logic [`PREG_W-1:0]  commit_preg,
    input  logic [`PREG_W-1:0]  prev_preg,
    output logic [`XLEN-1:0]    commit_value
);
    localparam int AREG_NUM = 1 << `AREG_W;
    localparam int FREE_NUM = `PREG_NUM - AREG_NUM;
    localparam int FREE_W   = $clog2(FREE_NUM);

    logic [`XLEN-1:0]   values [`PREG_NUM];
    logic [`PREG_NUM-1:0] ready;
    logic [`PREG_W-1:0] free_list [FREE_NUM];
    logic [FREE_W-1:0]  head, tail;
    logic [FREE_W:0]    free_count;
    logic               pop, push, cdb_wr, hit_a, hit_b;

    assign pop    = fire && alloc;
    assign push   = commit_valid && commit_preg != '0; // x0 writes hold no preg
    assign cdb_wr = cdb.valid && cdb.preg != '0;
    assign hit_a  = cdb_wr && cdb.preg == opa_preg;
    assign hit_b  = cdb_wr && cdb.preg == opb_preg;

    assign free_empty   = free_count == '0;
    assign new_preg     = alloc ? free_list[head] : '0;
    assign opa_ready    = ready[opa_preg] || hit_a;
    assign opa_value    = hit_a ? cdb.value : values[opa_preg];
    assign opb_ready    = ready[opb_preg] || hit_b;
    assign opb_value    = hit_b ? cdb.value : values[opb_preg];
    assign commit_value = values[commit_preg];

    //////////////////////////////
    // register state and list
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `PREG_NUM; i++) begin
                values[i] <= '0;
                ready[i]  <= i < AREG_NUM;
            end
            for (int i = 0; i < FREE_NUM; i++)
                free_list[i] <= `PREG_W'(AREG_NUM + i);
            head       <= '0;
            tail       <= '0;
            free_count <= (FREE_W+1)'(FREE_NUM);
        end else begin
            if (pop) begin
                ready[new_preg] <= 1'b0;    // waits for its producer
                head <= head + 1'b1;
            end
            if (cdb_wr) begin
                values[cdb.preg] <= cdb.value;
                ready[cdb.preg]  <= 1'b1;
            end
            if (push) begin
                free_list[tail] <= prev_preg;
                tail <= tail + 1'b1;
            end
            free_count <= free_count + (FREE_W+1)'(push) - (FREE_W+1)'(pop);
        end
    end

    // decode must hold back an allocating dispatch on an empty list
    assert property (@(posedge clock) disable iff (reset) pop |-> !free_empty)
        else $error("free list popped while empty");

endmodule

`default_nettype wire

//--- issue/rs_alu.sv
// ALU reservation station
// new entry goes to the lowest free slot, an immediate is a ready opb
// operands wake up from the CDB one edge after the broadcast
// issue picks the oldest entry whose operands are both ready
`timescale 1ns/10ps
`default_nettype none
`include "ooo_defines.svh"

module rs_alu import ooo_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                fire,
    input  logic [`PREG_W-1:0]  opa_preg,
    input  logic                opa_ready,
    input  logic [`XLEN-1:0]    opa_value,
    input  logic [`PREG_W-1:0]  opb_preg,
    input  logic                opb_ready,
    input  logic [`XLEN-1:0]    opb_value,
    input  logic [`XLEN-1:0]    imm,
    input  logic                opb_is_imm,
    input  alu_func_e           func,
    input  logic [`PREG_W-1:0]  dest_preg,
    input  logic [`ROB_W-1:0]   rob_idx,
    output logic                rs_full,
    cdb_if.dst                  cdb,
    output logic                issue_valid,
    output rs_entry_t           issue_entry
);
    localparam int IDX_W = $clog2(`RS_DEPTH);

    rs_entry_t              entries [`RS_DEPTH];
    rs_entry_t              new_entry;
    logic [`RS_DEPTH-1:0]   valid, ready_vec;
    logic [`RS_DEPTH-1:0]   older_than [`RS_DEPTH];  // bit j set when j is older
    logic [IDX_W-1:0]       free_idx, issue_idx;

    assign rs_full     = &valid;
    assign issue_entry = entries[issue_idx];

    always_comb begin
        new_entry           = '0;
        new_entry.opa       = '{value: opa_value, ready: opa_ready, tag: opa_preg};
        new_entry.opb       = '{value: opb_value, ready: opb_ready, tag: opb_preg};
        if (opb_is_imm)
            new_entry.opb   = '{value: imm, ready: 1'b1, tag: '0};
        new_entry.func      = func;
        new_entry.dest_preg = dest_preg;
        new_entry.rob_idx   = rob_idx;
    end

    //////////////////////////////
    // slot pick and oldest ready
    //////////////////////////////
    always_comb begin
        free_idx    = '0;
        issue_idx   = '0;
        issue_valid = 1'b0;
        for (int i = 0; i < `RS_DEPTH; i++)
            ready_vec[i] = valid[i] && entries[i].opa.ready && entries[i].opb.ready;
        for (int i = `RS_DEPTH-1; i >= 0; i--)
            if (!valid[i]) free_idx = IDX_W'(i);   // lowest wins
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (ready_vec[i] && !(|(ready_vec & older_than[i]))) begin
                issue_valid = 1'b1;
                issue_idx   = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
        end else begin
            if (issue_valid) valid[issue_idx] <= 1'b0;
            if (fire)        valid[free_idx]  <= 1'b1;
        end
    end

    // payload and age order, meaningful only under valid
    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (cdb.valid && !entries[i].opa.ready && entries[i].opa.tag == cdb.preg) begin
                entries[i].opa.value <= cdb.value;
                entries[i].opa.ready <= 1'b1;
            end
            if (cdb.valid && !entries[i].opb.ready && entries[i].opb.tag == cdb.preg) begin
                entries[i].opb.value <= cdb.value;
                entries[i].opb.ready <= 1'b1;
            end
        end
        if (fire) begin
            for (int j = 0; j < `RS_DEPTH; j++)
                older_than[j][free_idx] <= 1'b0;  // newcomer is youngest
            older_than[free_idx] <= valid;
            entries[free_idx]    <= new_entry;
        end
    end

endmodule

`default_nettype wire

//--- issue/alu.sv
// single-cycle RV32I ALU, its output register is the CDB
// shifts use opb[4:0] only
`timescale 1ns/10ps
`default_nettype none
`include "ooo_defines.svh"

module alu import ooo_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  logic        issue_valid,
    input  rs_entry_t   issue_entry,
    cdb_if.src          cdb
);
    logic [`XLEN-1:0] a, b, result;
    logic [4:0]       shamt;

    assign a     = issue_entry.opa.value;
    assign b     = issue_entry.opb.value;
    assign shamt = b[4:0];

    always_comb begin
        case (issue_entry.func)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = `XLEN'($signed(a) < $signed(b));
            ALU_SLTU: result = `XLEN'(a < b);
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;    // keeps the sign
            ALU_OR:   result = a | b;
            default:  result = a & b;                   // AND
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) cdb.valid <= 1'b0;
        else       cdb.valid <= issue_valid;   // one cycle per issue
    end

    always_ff @(posedge clock) begin
        cdb.preg    <= issue_entry.dest_preg;
        cdb.rob_idx <= issue_entry.rob_idx;
        cdb.value   <= result;
    end

endmodule

`default_nettype wire

//--- hdl/decode.sv
// decode of one raw RV32I word, OP and OP-IMM groups only
// other opcodes are not recognised and decode as garbage
// fire is the single dispatch strobe for the whole core
`timescale 1ns/10ps
`default_nettype none
`include "ooo_defines.svh"

module decode import ooo_pkg::*; (
    input  logic                inst_valid,
    input  inst_t               inst,
    input  logic                rob_full,
    input  logic                rs_full,
    input  logic                free_empty,
    output logic                fire,
    output logic [`AREG_W-1:0]  opa_areg,
    output logic [`AREG_W-1:0]  opb_areg,
    output logic [`AREG_W-1:0]  dest_areg,
    output alu_func_e           func,
    output logic [`XLEN-1:0]    imm,
    output logic                opb_is_imm,
    output logic                dispatch_stall
);
    logic is_op;    // register-register form

    assign is_op      = inst.r_view.opcode == `RV32_OP;
    assign opb_is_imm = inst.i_view.opcode == `RV32_OP_IMM;
    assign opa_areg   = inst.r_view.rs1;
    assign opb_areg   = inst.r_view.rs2;   // unused by the I form
    assign dest_areg  = inst.r_view.rd;
    assign imm        = {{(`XLEN-12){inst.i_view.imm12[11]}}, inst.i_view.imm12};

    always_comb begin
        case (inst.r_view.funct3)
            3'b000:  func = (is_op && inst.r_view.funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  func = ALU_SLL;
            3'b010:  func = ALU_SLT;
            3'b011:  func = ALU_SLTU;
            3'b100:  func = ALU_XOR;
            3'b101:  func = inst.r_view.funct7[5] ? ALU_SRA : ALU_SRL; // imm[10] for SRAI
            3'b110:  func = ALU_OR;
            default: func = ALU_AND;
        endcase
    end

    // x0 writes need no free preg
    assign dispatch_stall = rob_full || rs_full || (free_empty && dest_areg != `ZERO_REG);
    assign fire           = inst_valid && !dispatch_stall;

endmodule

`default_nettype wire

//--- hdl/rob.sv
// reorder buffer, retires strictly in program order
// commit_valid is combinational from a done head, one retire per cycle
// an x0 write carries preg 0 so nothing is freed at its commit
`timescale 1ns/10ps
`default_nettype none
`include "ooo_defines.svh"

module rob (
    input  logic                clock,
    input  logic                reset,
    input  logic                fire,
    input  logic [`AREG_W-1:0]  dest_areg,
    input  logic [`PREG_W-1:0]  new_preg,
    input  logic [`PREG_W-1:0]  old_preg,
    output logic [`ROB_W-1:0]   rob_tail,
    output logic                rob_full,
    cdb_if.dst                  cdb,
    output logic                commit_valid,
    output logic [`AREG_W-1:0]  commit_areg,
    output logic [`PREG_W-1:0]  commit_preg,
    output logic [`PREG_W-1:0]  prev_preg
);
    logic [`ROB_DEPTH-1:0] done;
    logic [`AREG_W-1:0]    areg_q [`ROB_DEPTH];
    logic [`PREG_W-1:0]    preg_q [`ROB_DEPTH];
    logic [`PREG_W-1:0]    prev_q [`ROB_DEPTH];
    logic [`ROB_W-1:0]     head;
    logic [`ROB_W:0]       count;

    assign rob_full     = count == (`ROB_W+1)'(`ROB_DEPTH);
    assign commit_valid = count != '0 && done[head];
    assign commit_areg  = areg_q[head];
    assign commit_preg  = preg_q[head];
    assign prev_preg    = prev_q[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            head     <= '0;
            rob_tail <= '0;
            count    <= '0;
        end else begin
            if (fire)         rob_tail <= rob_tail + 1'b1;
            if (commit_valid) head     <= head + 1'b1;
            count <= count + (`ROB_W+1)'(fire) - (`ROB_W+1)'(commit_valid);
        end
    end

    // entry payload, only read under count
    always_ff @(posedge clock) begin
        if (cdb.valid) done[cdb.rob_idx] <= 1'b1;
        if (fire) begin
            done[rob_tail]   <= 1'b0;
            areg_q[rob_tail] <= dest_areg;
            preg_q[rob_tail] <= new_preg;
            prev_q[rob_tail] <= old_preg;
        end
    end

    // the head retires only after its broadcast is over
    assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> !(cdb.valid && cdb.rob_idx == head))
        else $error("retire of ROB entry %0d before its result", head);

endmodule

`default_nettype wire

//--- hdl/ooo_core.sv
// out-of-order integer core, top level
// one instruction per cycle in, no handshake beyond dispatch_stall,
// the source holds inst while the stall is high
// one retirement per commit_valid cycle, in program order
`timescale 1ns/10ps
`default_nettype none
`include "ooo_defines.svh"

module ooo_core import ooo_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                inst_valid,
    input  logic [31:0]         inst,
    output logic                dispatch_stall,
    output logic                commit_valid,
    output logic [`AREG_W-1:0]  commit_areg,
    output logic [`XLEN-1:0]    commit_value
);
    logic               fire, opb_is_imm, rob_full, rs_full, free_empty;
    logic [`AREG_W-1:0] opa_areg, opb_areg, dest_areg;
    alu_func_e          func;
    logic [`XLEN-1:0]   imm, opa_value, opb_value;
    logic [`PREG_W-1:0] opa_preg, opb_preg, old_preg, new_preg;   // rat, prf
    logic               opa_ready, opb_ready;                     // prf -> rs
    logic [`PREG_W-1:0] commit_preg, prev_preg;                   // rob -> prf
    logic [`ROB_W-1:0]  rob_tail;
    logic               issue_valid;                              // rs -> alu
    rs_entry_t          issue_entry;

    cdb_if cdb_bus ();

    //////////////////////////////
    // dispatch
    //////////////////////////////
    decode decode_inst (
        .inst_valid, .inst, .rob_full, .rs_full, .free_empty, .fire,
        .opa_areg, .opb_areg, .dest_areg, .func, .imm, .opb_is_imm, .dispatch_stall
    );

    rat rat_inst (
        .clock, .reset, .fire, .opa_areg, .opb_areg, .dest_areg, .new_preg,
        .opa_preg, .opb_preg, .old_preg
    );

    prf prf_inst (
        .clock, .reset, .fire, .alloc(dest_areg != `ZERO_REG),
        .opa_preg, .opb_preg, .opa_ready, .opa_value, .opb_ready, .opb_value,
        .new_preg, .free_empty, .cdb(cdb_bus.dst),
        .commit_valid, .commit_preg, .prev_preg, .commit_value
    );

    //////////////////////////////
    // issue, execute, retire
    //////////////////////////////
    rs_alu rs_alu_inst (
        .clock, .reset, .fire,
        .opa_preg, .opa_ready, .opa_value, .opb_preg, .opb_ready, .opb_value,
        .imm, .opb_is_imm, .func, .dest_preg(new_preg), .rob_idx(rob_tail),
        .rs_full, .cdb(cdb_bus.dst), .issue_valid, .issue_entry
    );

    alu alu_inst (
        .clock, .reset, .issue_valid, .issue_entry, .cdb(cdb_bus.src)
    );

    rob rob_inst (
        .clock, .reset, .fire, .dest_areg, .new_preg, .old_preg,
        .rob_tail, .rob_full, .cdb(cdb_bus.dst),
        .commit_valid, .commit_areg, .commit_preg, .prev_preg
    );

endmodule

`default_nettype wire

//--- tests/ooo_core_tb.sv
// testbench for the out-of-order core
// a table of raw OP and OP-IMM words is filled first, with expected
// retire values from an architectural register model, then streamed in
// commits are matched in order on the falling edge
// stimulus changes 1 ns after the rising edge, random part seeded with 53
`timescale 1ns/10ps
`default_nettype none

module ooo_core_tb;
    localparam int         CLK_PERIOD = 8;
    localparam int         RAND_NUM   = 64;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;

    typedef struct {
        logic [31:0] word;
        logic [4:0]  areg;     // expected destination
        logic [31:0] value;    // expected retire value
    } stim_t;

    logic        clock, reset, inst_valid;
    logic [31:0] inst;
    logic        dispatch_stall, commit_valid;
    logic [4:0]  commit_areg;
    logic [31:0] commit_value;

    stim_t       stim_table [$];
    logic [31:0] arch_regs [32];    // reference register file
    int          mismatch_count = 0;
    int          extra_count    = 0;
    int          commit_idx     = 0;

    ooo_core ooo_core_inst (
        .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
        .dispatch_stall(dispatch_stall), .commit_valid(commit_valid),
        .commit_areg(commit_areg), .commit_value(commit_value)
    );

    always #(CLK_PERIOD/2) clock = ~clock;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_IMM};
    endfunction

    //////////////////////////////
    // reference model and table
    //////////////////////////////
    task automatic add_inst(input logic [31:0] w);
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic        is_r, alt;
        logic [31:0] a, b, res;
        stim_t       rec;
        rd   = w[11:7];
        f3   = w[14:12];
        rs1  = w[19:15];
        rs2  = w[24:20];
        is_r = w[6:0] == OPC_OP;
        alt  = w[30];                   // SUB, SRA, SRAI
        a    = arch_regs[rs1];
        b    = is_r ? arch_regs[rs2] : {{20{w[31]}}, w[31:20]};
        case (f3)
            3'd0:    res = (is_r && alt) ? a - b : a + b;
            3'd1:    res = a << b[4:0];
            3'd2:    res = {31'b0, $signed(a) < $signed(b)};
            3'd3:    res = {31'b0, a < b};
            3'd4:    res = a ^ b;
            3'd5: begin
                if (alt) res = $signed(a) >>> b[4:0];
                else     res = a >> b[4:0];
            end
            3'd6:    res = a | b;
            default: res = a & b;
        endcase
        if (rd == 5'd0) res = '0;       // x0 retires as zero
        else            arch_regs[rd] = res;
        rec.word  = w;
        rec.areg  = rd;
        rec.value = res;
        stim_table.push_back(rec);
    endtask

    function automatic logic [31:0] random_inst();
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3  = 3'($urandom % 8);
        rd  = 5'($urandom % 8);        // few registers, many dependencies
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        imm = 12'($urandom);
        f7  = '0;
        if ((f3 == 3'd0 || f3 == 3'd5) && $urandom % 2) f7 = 7'h20;
        if ($urandom % 2) return r_type(f7, rs2, rs1, f3, rd);
        if (f3 == 3'd1) imm = {7'h00, imm[4:0]};   // legal SLLI
        if (f3 == 3'd5) imm = {f7, imm[4:0]};      // SRLI or SRAI
        return i_type(imm, rs1, f3, rd);
    endfunction

    task automatic build_table();
        for (int i = 0; i < 32; i++) arch_regs[i] = '0;
        add_inst(i_type(12'd100, 5'd0, 3'd0, 5'd1));        // addi x1 = 100
        add_inst(i_type(12'hff9, 5'd0, 3'd0, 5'd2));        // addi x2 = -7
        add_inst(r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));    // add
        add_inst(r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4));    // sub
        add_inst(r_type(7'h00, 5'd2, 5'd1, 3'd1, 5'd5));    // sll by 25
        add_inst(r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd6));    // slt
        add_inst(r_type(7'h00, 5'd1, 5'd2, 3'd3, 5'd7));    // sltu
        add_inst(r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd8));    // xor
        add_inst(r_type(7'h00, 5'd1, 5'd2, 3'd5, 5'd9));    // srl by 4
        add_inst(r_type(7'h20, 5'd1, 5'd2, 3'd5, 5'd10));   // sra by 4
        add_inst(r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd11));   // or
        add_inst(r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd12));   // and
        add_inst(i_type(12'h003, 5'd1, 3'd1, 5'd13));       // slli
        add_inst(i_type(12'hffb, 5'd2, 3'd2, 5'd14));       // slti -5
        add_inst(i_type(12'h005, 5'd2, 3'd3, 5'd15));       // sltiu
        add_inst(i_type(12'hfff, 5'd1, 3'd4, 5'd16));       // xori -1
        add_inst(i_type(12'h01c, 5'd2, 3'd5, 5'd17));       // srli 28
        add_inst(i_type(12'h402, 5'd2, 3'd5, 5'd18));       // srai 2
        add_inst(i_type(12'h0f0, 5'd1, 3'd6, 5'd19));       // ori
        add_inst(i_type(12'h0ff, 5'd2, 3'd7, 5'd20));       // andi
        // back to back chain through x21
        for (int i = 0; i < 4; i++) add_inst(i_type(12'd1, 5'd21, 3'd0, 5'd21));
        add_inst(r_type(7'h00, 5'd21, 5'd21, 3'd0, 5'd22));
        add_inst(r_type(7'h20, 5'd1, 5'd22, 3'd0, 5'd22));
        add_inst(i_type(12'd1, 5'd0, 3'd0, 5'd5));          // rewrite x5 three times
        add_inst(i_type(12'd2, 5'd5, 3'd0, 5'd5));
        add_inst(i_type(12'd3, 5'd5, 3'd0, 5'd5));
        add_inst(i_type(12'd5, 5'd1, 3'd0, 5'd0));          // x0 writes
        add_inst(r_type(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
        add_inst(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd23));   // read of x0
        for (int i = 0; i < RAND_NUM; i++) add_inst(random_inst());
    endtask

    //////////////////////////////
    // commit monitor
    //////////////////////////////
    always @(negedge clock) begin
        if (!reset && commit_valid === 1'b1) begin
            if (commit_idx >= stim_table.size()) begin
                extra_count++;
                $display("extra commit of x%0d at %0t, every instruction had already retired",
                         commit_areg, $time);
            end else begin
                check_value($sformatf("entry %0d areg", commit_idx), 32'(commit_areg),
                            32'(stim_table[commit_idx].areg));
                check_value($sformatf("entry %0d value", commit_idx), commit_value,
                            stim_table[commit_idx].value);
            end
            commit_idx++;
        end
    end

    initial begin
        longint limit_cycles;
        logic   stalled;
        clock      = 1'b0;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        void'($urandom(53));
        build_table();
        limit_cycles = longint'(stim_table.size()) * 20 + 100;
        fork
            begin   // watchdog
                #(limit_cycles * CLK_PERIOD);
                $display("timeout after %0d cycles, %0d of %0d instructions retired",
                         limit_cycles, commit_idx, stim_table.size());
                $display("CHECKS FAILED");
                $finish;
            end
        join_none
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        // idle core after reset
        repeat (3) begin
            @(negedge clock);
            check_value("idle commit_valid", 32'(commit_valid), 32'd0);
            check_value("idle dispatch_stall", 32'(dispatch_stall), 32'd0);
        end
        @(posedge clock);
        #1;
        foreach (stim_table[i]) begin
            inst_valid = 1'b1;
            inst       = stim_table[i].word;
            do begin    // hold the word until it is taken
                @(negedge clock);
                stalled = dispatch_stall;
                @(posedge clock);
                #1;
            end while (stalled);
        end
        inst_valid = 1'b0;
        wait (commit_idx >= stim_table.size());
        repeat (10) @(posedge clock);   // room for stray commits
        $display("%0d value mismatches, %0d extra commits, %0d of %0d retired",
                 mismatch_count, extra_count, commit_idx, stim_table.size());
        if (mismatch_count == 0 && extra_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/ooo_pkg.sv
common/cdb_if.sv
rename/rat.sv
rename/prf.sv
issue/rs_alu.sv
issue/alu.sv
hdl/decode.sv
hdl/rob.sv
hdl/ooo_core.sv
tests/ooo_core_tb.sv

//--- Bender.yml
package:
  name: ooo_core

export_include_dirs:
  - common

sources:
  - common/ooo_pkg.sv
  - common/cdb_if.sv
  - rename/rat.sv
  - rename/prf.sv
  - issue/rs_alu.sv
  - issue/alu.sv
  - hdl/decode.sv
  - hdl/rob.sv
  - hdl/ooo_core.sv
  - target: test
    files:
      - tests/ooo_core_tb.sv
